// ==== hw/gat_pkg.sv ====
// Graph-attention layer sizes, derived widths and the structs passed between stages
package gat_pkg;

  // ====================
  // Layer sizes
  // ====================
  localparam int DATA_W       = 8;
  localparam int NUM_FEAT_IN  = 4;
  localparam int NUM_FEAT_OUT = 4;
  localparam int NODE_ID_W    = 8;

  // Full-precision accumulator widths
  localparam int WH_W    = 2 * DATA_W + $clog2(NUM_FEAT_IN);
  localparam int SCORE_W = DATA_W + WH_W + $clog2(NUM_FEAT_OUT);

  // W rows first (output index major), then the attention vector
  localparam int W_ENTRIES     = NUM_FEAT_IN * NUM_FEAT_OUT;
  localparam int WEIGHT_DEPTH  = NUM_FEAT_OUT * (NUM_FEAT_IN + 1);
  localparam int WEIGHT_ADDR_W = $clog2(WEIGHT_DEPTH);

  // ====================
  // Element types
  // ====================
  typedef logic signed [DATA_W-1:0]  data_t;
  typedef logic signed [WH_W-1:0]    wh_elem_t;
  typedef logic signed [SCORE_W-1:0] score_t;

  typedef data_t    [NUM_FEAT_IN-1:0]  feat_vec_t;
  typedef feat_vec_t [NUM_FEAT_OUT-1:0] w_mat_t;
  typedef data_t    [NUM_FEAT_OUT-1:0] attn_vec_t;
  typedef wh_elem_t [NUM_FEAT_OUT-1:0] wh_vec_t;

  // ====================
  // Stage structs
  // ====================
  typedef struct packed {
    logic                     we;
    logic [WEIGHT_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]        data;
  } wgt_wr_t;

  typedef struct packed {
    w_mat_t    w;
    attn_vec_t a;
  } weight_set_t;

  typedef struct packed {
    logic                 valid;
    logic [NODE_ID_W-1:0] id;
    feat_vec_t            feat;
  } node_t;

  typedef struct packed {
    logic                 valid;
    logic [NODE_ID_W-1:0] id;
    wh_vec_t              wh;
  } wh_t;

  typedef struct packed {
    logic                 valid;
    logic [NODE_ID_W-1:0] id;
    wh_vec_t              wh;
    score_t               score;
  } result_t;

endpackage

// ==== hw/weight_bank.sv ====
// Weight and attention-vector memory with host write port and load scan into working registers
`timescale 1ns/100ps

module weight_bank
  import gat_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  wgt_wr_t     wgt_wr_i,
  input  logic        wgt_load_done_i,
  output weight_set_t weights_o,
  output logic        ready_o
);

  localparam logic [WEIGHT_ADDR_W-1:0] LAST_ADDR = WEIGHT_ADDR_W'(WEIGHT_DEPTH - 1);

  logic [DATA_W-1:0]        mem [WEIGHT_DEPTH];
  logic [WEIGHT_ADDR_W-1:0] scan_addr;
  logic                     scanning;
  logic [DATA_W-1:0]        rd_data;
  logic [WEIGHT_ADDR_W-1:0] rd_addr;
  logic                     rd_vld;
  logic                     last_stored;

  // ====================
  // Memory
  // ====================
  always_ff @(posedge clk) begin
    if (wgt_wr_i.we && (wgt_wr_i.addr <= LAST_ADDR)) begin
      mem[wgt_wr_i.addr] <= wgt_wr_i.data;
    end
    rd_data <= mem[scan_addr];
    rd_addr <= scan_addr;
  end

  // ====================
  // Scan control
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      scanning    <= 1'b0;
      scan_addr   <= '0;
      rd_vld      <= 1'b0;
      last_stored <= 1'b0;
      ready_o     <= 1'b0;
    end else if (wgt_load_done_i) begin
      // Also restarts a scan already running
      scanning    <= 1'b1;
      scan_addr   <= '0;
      rd_vld      <= 1'b0;
      last_stored <= 1'b0;
      ready_o     <= 1'b0;
    end else begin
      rd_vld      <= scanning;
      last_stored <= rd_vld && (rd_addr == LAST_ADDR);
      if (last_stored) begin
        ready_o <= 1'b1;
      end
      if (scanning) begin
        if (scan_addr == LAST_ADDR) begin
          scanning  <= 1'b0;
          scan_addr <= '0;
        end else begin
          scan_addr <= scan_addr + 1'b1;
        end
      end
    end
  end

  // Steer each returned byte into its W or a slot
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      weights_o <= '0;
    end else if (rd_vld) begin
      for (int o = 0; o < NUM_FEAT_OUT; o++) begin
        for (int i = 0; i < NUM_FEAT_IN; i++) begin
          if (rd_addr == WEIGHT_ADDR_W'(o * NUM_FEAT_IN + i)) begin
            weights_o.w[o][i] <= rd_data;
          end
        end
        if (rd_addr == WEIGHT_ADDR_W'(W_ENTRIES + o)) begin
          weights_o.a[o] <= rd_data;
        end
      end
    end
  end

endmodule

// ==== hw/feature_transform.sv ====
// First pipeline stage, linear transform Wh of each accepted node
`timescale 1ns/100ps

module feature_transform
  import gat_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  node_t       node_i,
  input  weight_set_t weights_i,
  input  logic        ready_i,
  output wh_t         wh_o
);

  wh_vec_t wh_sum;
  logic    accept;

  // Nodes arriving while the weights are not ready are dropped
  assign accept = node_i.valid & ready_i;

  // ====================
  // Dot products
  // ====================
  // One row of W per output feature, all rows in parallel
  always_comb begin
    for (int o = 0; o < NUM_FEAT_OUT; o++) begin
      wh_sum[o] = '0;
      for (int i = 0; i < NUM_FEAT_IN; i++) begin
        wh_sum[o] = wh_sum[o]
                  + $signed(weights_i.w[o][i]) * $signed(node_i.feat[i]);
      end
    end
  end

  // ====================
  // Stage register
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wh_o <= '0;
    end else begin
      wh_o.valid <= accept;
      wh_o.id    <= node_i.id;
      wh_o.wh    <= wh_sum;
    end
  end

endmodule

// ==== hw/attention_score.sv ====
// Attention score stages, dot product with a followed by a power-of-two LeakyReLU
`timescale 1ns/100ps

module attention_score
  import gat_pkg::*;
#(
  parameter int unsigned LRELU_SHIFT = 3
)(
  input  logic      clk,
  input  logic      rst_n,
  input  wh_t       wh_i,
  input  attn_vec_t attn_i,
  output result_t   result_o
);

  score_t  raw_sum;
  score_t  act_score;
  result_t s2_q;

  // ====================
  // Stage 2
  // ====================
  always_comb begin
    raw_sum = '0;
    for (int o = 0; o < NUM_FEAT_OUT; o++) begin
      raw_sum = raw_sum + $signed(attn_i[o]) * $signed(wh_i.wh[o]);
    end
  end

  // Score field holds the raw sum until stage 3
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s2_q <= '0;
    end else begin
      s2_q.valid <= wh_i.valid;
      s2_q.id    <= wh_i.id;
      s2_q.wh    <= wh_i.wh;
      s2_q.score <= raw_sum;
    end
  end

  // ====================
  // Stage 3
  // ====================
  // Negative slope of 2^-LRELU_SHIFT, shift rounds toward minus infinity
  always_comb begin
    if (s2_q.score[SCORE_W-1]) begin
      act_score = $signed(s2_q.score) >>> LRELU_SHIFT;
    end else begin
      act_score = s2_q.score;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_o <= '0;
    end else begin
      result_o.valid <= s2_q.valid;
      result_o.id    <= s2_q.id;
      result_o.wh    <= s2_q.wh;
      result_o.score <= act_score;
    end
  end

endmodule

// ==== hw/gat_layer_top.sv ====
// Graph-attention layer top, weight bank feeding the transform and score pipeline
`timescale 1ns/100ps

module gat_layer_top
  import gat_pkg::*;
#(
  parameter int unsigned LRELU_SHIFT = 3
)(
  input  logic    clk,
  input  logic    rst_n,
  input  wgt_wr_t wgt_wr_i,
  input  logic    wgt_load_done_i,
  input  node_t   node_i,
  output logic    ready_o,
  output result_t result_o
);

  weight_set_t weights;
  wh_t         wh;

  weight_bank u_weight_bank (
    .clk             (clk            ),
    .rst_n           (rst_n          ),
    .wgt_wr_i        (wgt_wr_i       ),
    .wgt_load_done_i (wgt_load_done_i),
    .weights_o       (weights        ),
    .ready_o         (ready_o        )
  );

  feature_transform u_feature_transform (
    .clk       (clk    ),
    .rst_n     (rst_n  ),
    .node_i    (node_i ),
    .weights_i (weights),
    .ready_i   (ready_o),
    .wh_o      (wh     )
  );

  attention_score #(
    .LRELU_SHIFT (LRELU_SHIFT)
  ) u_attention_score (
    .clk      (clk      ),
    .rst_n    (rst_n    ),
    .wh_i     (wh       ),
    .attn_i   (weights.a),
    .result_o (result_o )
  );

endmodule

// ==== verif/gat_layer_checker.sv ====
// Concurrent checks on the graph-attention layer top, bound into the DUT
`timescale 1ns/100ps

module gat_layer_checker
  import gat_pkg::*;
(
  input logic    clk,
  input logic    rst_n,
  input logic    wgt_load_done_i,
  input node_t   node_i,
  input logic    ready_o,
  input result_t result_o
);

  int fail_cnt = 0;

  // Every result traces back to an accepted node three edges earlier
  result_from_accepted: assert property (@(posedge clk) disable iff (!rst_n)
    result_o.valid |-> $past(node_i.valid && ready_o, 3)
  ) else begin
    fail_cnt++;
    $error("result_o.valid without an accepted node three cycles earlier");
  end

  ready_drops_on_load: assert property (@(posedge clk) disable iff (!rst_n)
    wgt_load_done_i |=> !ready_o
  ) else begin
    fail_cnt++;
    $error("ready_o still high on the cycle after wgt_load_done_i");
  end

  valid_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(result_o.valid)
  ) else begin
    fail_cnt++;
    $error("result_o.valid is unknown after reset");
  end

endmodule

bind gat_layer_top gat_layer_checker u_checker (.*);

// ==== verif/gat_layer_tb.sv ====
// Testbench for the graph-attention layer, random stimulus checked against a reference model
`timescale 1ns/100ps

module gat_layer_tb
  import gat_pkg::*;
();

  localparam int          CLK_PERIOD   = 20;
  localparam int          DRIVE_DLY    = 2;
  localparam int          RESET_CYCLES = 16;
  localparam int          LRELU_SHIFT  = 3;
  localparam longint      SLOPE_DIV    = longint'(1) << LRELU_SHIFT;
  localparam int          NUM_TESTS    = 5;
  localparam int          TIMEOUT_NS   = NUM_TESTS * (WEIGHT_DEPTH + 220) * CLK_PERIOD;
  localparam int unsigned SEED         = 32'h5d66c783;

  logic    clk;
  logic    rst_n;
  wgt_wr_t wgt_wr_i;
  logic    wgt_load_done_i;
  node_t   node_i;
  logic    ready_o;
  result_t result_o;

  // Reference model state
  data_t          mdl_mem [WEIGHT_DEPTH];
  data_t          mdl_w   [NUM_FEAT_OUT][NUM_FEAT_IN];
  data_t          mdl_a   [NUM_FEAT_OUT];
  logic           exp_ready;
  result_t        exp_q [$];
  int             due_q [$];
  logic [NODE_ID_W-1:0] node_id = '0;
  int             cyc = 0;
  int             due_cyc;
  int             pass_cnt = 0;
  int             err_cnt = 0;
  int             test_err_base = 0;

  gat_layer_top DUT (
    .clk             (clk            ),
    .rst_n           (rst_n          ),
    .wgt_wr_i        (wgt_wr_i       ),
    .wgt_load_done_i (wgt_load_done_i),
    .node_i          (node_i         ),
    .ready_o         (ready_o        ),
    .result_o        (result_o       )
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  // ====================
  // Model and checks
  // ====================
  function automatic result_t expect_result(input node_t n);
    result_t r;
    longint  acc;
    longint  s;
    r = '0;
    r.valid = 1'b1;
    r.id = n.id;
    s = 0;
    for (int o = 0; o < NUM_FEAT_OUT; o++) begin
      acc = 0;
      for (int i = 0; i < NUM_FEAT_IN; i++) begin
        acc += longint'(mdl_w[o][i]) * longint'($signed(n.feat[i]));
      end
      r.wh[o] = wh_elem_t'(acc);
      s += longint'(mdl_a[o]) * acc;
    end
    // Floor division for the negative slope
    if (s < 0) s = -((-s + SLOPE_DIV - 1) / SLOPE_DIV);
    r.score = score_t'(s);
    return r;
  endfunction

  task automatic check_result(input result_t exp, input result_t act);
    bit ok;
    ok = 1'b1;
    if (act.id !== exp.id) begin
      $display("ERR %0t result_o.id exp=%0d act=%0d", $time, exp.id, act.id);
      ok = 1'b0;
    end
    for (int o = 0; o < NUM_FEAT_OUT; o++) begin
      if (act.wh[o] !== exp.wh[o]) begin
        $display("ERR %0t result_o.wh[%0d] exp=%0d act=%0d", $time, o, exp.wh[o], act.wh[o]);
        ok = 1'b0;
      end
    end
    if (act.score !== exp.score) begin
      $display("ERR %0t result_o.score exp=%0d act=%0d", $time, exp.score, act.score);
      ok = 1'b0;
    end
    if (ok) pass_cnt++;
    else err_cnt++;
  endtask

  task automatic check_ready(input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %0t ready_o exp=%b act=%b", $time, exp, act);
      err_cnt++;
    end else begin
      pass_cnt++;
    end
  endtask

  // Results are sampled mid-cycle where they are stable
  always @(negedge clk) begin
    if (rst_n && result_o.valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("Unexpected result for node id %0d at %0t", result_o.id, $time);
        err_cnt++;
      end else begin
        check_result(exp_q.pop_front(), result_o);
        due_cyc = due_q.pop_front();
        if (cyc != due_cyc) begin
          $display("Result for node id %0d arrived in cycle %0d instead of cycle %0d",
                   result_o.id, cyc, due_cyc);
          err_cnt++;
        end
      end
    end
  end

  // ====================
  // Stimulus
  // ====================
  task automatic step();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  function automatic data_t rand_byte(input bit extreme);
    if (extreme) return ($urandom & 1) ? data_t'(127) : data_t'(-128);
    return data_t'($urandom);
  endfunction

  function automatic node_t make_node(input bit extreme, input bit fixed, input data_t v);
    node_t n;
    n.valid = 1'b1;
    n.id = node_id;
    node_id++;
    for (int i = 0; i < NUM_FEAT_IN; i++) begin
      n.feat[i] = fixed ? v : rand_byte(extreme);
    end
    return n;
  endfunction

  task automatic send_node(input node_t n);
    node_i = n;
    if (n.valid && exp_ready) begin
      exp_q.push_back(expect_result(n));
      due_q.push_back(cyc + 3);
    end
    step();
  endtask

  task automatic write_word(input int addr, input data_t value);
    wgt_wr_i.we = 1'b1;
    wgt_wr_i.addr = WEIGHT_ADDR_W'(addr);
    wgt_wr_i.data = value;
    mdl_mem[addr] = value;
    step();
    wgt_wr_i.we = 1'b0;
  endtask

  // Mode 0 full range, 1 extremes only, 2 all at -128
  task automatic write_weights(input int mode);
    for (int k = 0; k < WEIGHT_DEPTH; k++) begin
      write_word(k, (mode == 2) ? data_t'(-128) : rand_byte(mode == 1));
    end
  endtask

  task automatic load_weights(input bit scan_nodes);
    wgt_load_done_i = 1'b1;
    exp_ready = 1'b0;
    for (int o = 0; o < NUM_FEAT_OUT; o++) begin
      for (int i = 0; i < NUM_FEAT_IN; i++) mdl_w[o][i] = mdl_mem[o * NUM_FEAT_IN + i];
      mdl_a[o] = mdl_mem[W_ENTRIES + o];
    end
    step();
    wgt_load_done_i = 1'b0;
    for (int k = 0; k < WEIGHT_DEPTH + 2; k++) begin
      check_ready(1'b0, ready_o);
      if (scan_nodes) node_i = make_node(1'b0, 1'b0, '0);
      step();
    end
    node_i.valid = 1'b0;
    check_ready(1'b1, ready_o);
    exp_ready = 1'b1;
  endtask

  task automatic drain(input string what);
    int waited;
    node_i.valid = 1'b0;
    waited = 0;
    while (exp_q.size() != 0 && waited < 8) begin
      step();
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("%s: %0d expected results never arrived", what, exp_q.size());
      err_cnt++;
      exp_q.delete();
      due_q.delete();
    end
    repeat (4) step();
  endtask

  task automatic report_test(input int num, input string name);
    drain(name);
    $display("Test %0d (%s) finished with %0d errors", num, name, err_cnt - test_err_base);
    test_err_base = err_cnt;
  endtask

  // ====================
  // Test sequence
  // ====================
  initial begin
    void'($urandom(SEED));
    wgt_wr_i = '0;
    wgt_load_done_i = 1'b0;
    node_i = '0;
    exp_ready = 1'b0;
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;

    check_ready(1'b0, ready_o);
    repeat (6) send_node(make_node(1'b0, 1'b0, '0));
    drain("nodes before first load");
    write_weights(0);
    load_weights(1'b0);
    report_test(1, "reset and first load");

    repeat (200) send_node(make_node(1'b0, 1'b0, '0));
    report_test(2, "back-to-back random nodes");

    write_weights(2);
    load_weights(1'b0);
    send_node(make_node(1'b0, 1'b1, data_t'(-128)));
    send_node(make_node(1'b0, 1'b1, data_t'(127)));
    drain("fixed extreme nodes");
    write_weights(1);
    load_weights(1'b0);
    repeat (40) send_node(make_node(1'b1, 1'b0, '0));
    report_test(3, "extreme values");

    write_weights(0);
    load_weights(1'b1);
    repeat (10) send_node(make_node(1'b0, 1'b0, '0));
    report_test(4, "nodes during scan");

    write_weights(0);
    load_weights(1'b0);
    repeat (30) send_node(make_node(1'b0, 1'b0, '0));
    drain("nodes after reload");
    repeat (8) write_word($urandom_range(WEIGHT_DEPTH - 1, 0), rand_byte(1'b0));
    repeat (30) send_node(make_node(1'b0, 1'b0, '0));
    report_test(5, "reload and writes without load");

    drain("final drain");
    err_cnt += DUT.u_checker.fail_cnt;
    $display("Checks passed: %0d, errors: %0d", pass_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: run did not finish within %0d ns", TIMEOUT_NS);
    $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== gat_layer.f ====
hw/gat_pkg.sv
hw/weight_bank.sv
hw/feature_transform.sv
hw/attention_score.sv
hw/gat_layer_top.sv
verif/gat_layer_checker.sv
verif/gat_layer_tb.sv

// ==== Bender.yml ====
package:
  name: gat_layer

sources:
  - files:
      - hw/gat_pkg.sv
      - hw/weight_bank.sv
      - hw/feature_transform.sv
      - hw/attention_score.sv
      - hw/gat_layer_top.sv
  - target: test
    files:
      - verif/gat_layer_checker.sv
      - verif/gat_layer_tb.sv
